// ==== rv_pipe_defines.svh ====
// RV32 sizes are fixed; only four machine CSRs exist and any other address decodes as a no-op
`ifndef RV_PIPE_DEFINES_SVH
`define RV_PIPE_DEFINES_SVH

`define RV_WORD_WD      32
`define RV_GPR_NUM      32
`define RV_GPR_ADDR_WD  5
`define RV_CSR_ADDR_WD  12
`define RV_CSR_NUM      4

// machine CSR addresses
`define RV_CSR_MSCRATCH 12'h340
`define RV_CSR_MTVEC    12'h305
`define RV_CSR_MEPC     12'h341
`define RV_CSR_MCAUSE   12'h342

`endif

// ==== rv_pipe_pkg.sv ====
// inter-stage buses; payload fields are only meaningful while the owning stage is valid
`include "rv_pipe_defines.svh"

package rv_pipe_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B,
    ALU_CSRW,
    ALU_CSRS,
    ALU_CSRC
  } alu_op_e;

  typedef logic [$clog2(`RV_CSR_NUM)-1:0] csr_idx_t;

  typedef struct packed {
    logic [`RV_WORD_WD-1:0] pc;
    logic [`RV_WORD_WD-1:0] inst;
  } fetch_bus_t;

  typedef struct packed {
    alu_op_e                    op;
    logic [`RV_WORD_WD-1:0]     src_a;
    logic [`RV_WORD_WD-1:0]     src_b;
    logic                       gpr_wen;
    logic [`RV_GPR_ADDR_WD-1:0] rd;
    logic                       csr_wen;
    csr_idx_t                   csr_idx;
    logic [`RV_WORD_WD-1:0]     csr_old;
    logic [`RV_WORD_WD-1:0]     pc;
    logic [`RV_WORD_WD-1:0]     inst;
  } ds_to_es_bus_t;

  typedef struct packed {
    logic                       gpr_wen;
    logic [`RV_GPR_ADDR_WD-1:0] rd;
    logic [`RV_WORD_WD-1:0]     gpr_result;
    logic                       csr_wen;
    csr_idx_t                   csr_idx;
    logic [`RV_WORD_WD-1:0]     csr_result;
    logic [`RV_WORD_WD-1:0]     pc;
    logic [`RV_WORD_WD-1:0]     inst;
  } es_to_ws_bus_t;

  typedef struct packed {
    logic                       gpr_wen;
    logic [`RV_GPR_ADDR_WD-1:0] gpr_waddr;
    logic [`RV_WORD_WD-1:0]     gpr_wdata;
    logic                       csr_wen;
    csr_idx_t                   csr_idx;
    logic [`RV_WORD_WD-1:0]     csr_wdata;
  } ws_to_rf_bus_t;

  // same layout, but every field is zero unless its write enable is set
  typedef ws_to_rf_bus_t bypass_bus_t;

  typedef struct packed {
    logic     pending;
    csr_idx_t idx;
  } csr_pending_t;

  typedef struct packed {
    logic                       valid;
    logic [`RV_WORD_WD-1:0]     pc;
    logic [`RV_WORD_WD-1:0]     inst;
    logic                       gpr_wen;
    logic [`RV_GPR_ADDR_WD-1:0] rd;
    logic [`RV_WORD_WD-1:0]     gpr_wdata;
    logic                       csr_wen;
    csr_idx_t                   csr_idx;
    logic [`RV_WORD_WD-1:0]     csr_wdata;
  } commit_t;

endpackage

// ==== stage_reg.sv ====
// payload is not reset and is only meaningful while o_valid is high
`timescale 1ns/1ps

module stage_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     i_clk,
  input  logic     i_reset,
  input  logic     i_up_valid,
  input  logic     i_allowin,
  input  payload_t i_up_data,
  output logic     o_valid,
  output payload_t o_data
);

  // valid follows upstream whenever this stage can take a new entry
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else if (i_allowin) begin
      o_valid <= i_up_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_up_valid && i_allowin) begin
      o_data <= i_up_data;
    end
  end

  // a held entry must survive until downstream lets it go
  a_hold_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    o_valid && !i_allowin |=> $stable(o_data));

endmodule

// ==== reg_file.sv ====
// reads are combinational and return the pre-edge value; x0 reads zero, CSRs by index only
`timescale 1ns/1ps
`include "rv_pipe_defines.svh"

module reg_file
  import rv_pipe_pkg::*;
(
  input  logic                       i_clk,
  input  logic                       i_reset,
  input  logic [`RV_GPR_ADDR_WD-1:0] i_rs1,
  input  logic [`RV_GPR_ADDR_WD-1:0] i_rs2,
  input  csr_idx_t                   i_csr_idx,
  input  ws_to_rf_bus_t              i_wb,
  output logic [`RV_WORD_WD-1:0]     o_rs1_data,
  output logic [`RV_WORD_WD-1:0]     o_rs2_data,
  output logic [`RV_WORD_WD-1:0]     o_csr_data
);

  logic [`RV_WORD_WD-1:0] gpr [`RV_GPR_NUM];
  logic [`RV_WORD_WD-1:0] csr [`RV_CSR_NUM];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < `RV_GPR_NUM; i++) begin
        gpr[i] <= '0;
      end
      for (int j = 0; j < `RV_CSR_NUM; j++) begin
        csr[j] <= '0;
      end
    end else begin
      // x0 is never written
      if (i_wb.gpr_wen && i_wb.gpr_waddr != '0) begin
        gpr[i_wb.gpr_waddr] <= i_wb.gpr_wdata;
      end
      if (i_wb.csr_wen) begin
        csr[i_wb.csr_idx] <= i_wb.csr_wdata;
      end
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : gpr[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : gpr[i_rs2];
  assign o_csr_data = csr[i_csr_idx];

endmodule

// ==== decode_stage.sv ====
// undecodable or unknown-CSR encodings pass on with no writes; one-cycle stall on a CSR hazard
`timescale 1ns/1ps
`include "rv_pipe_defines.svh"

module decode_stage
  import rv_pipe_pkg::*;
(
  input  logic                       i_clk,
  input  logic                       i_reset,
  input  logic                       i_inst_valid,
  input  fetch_bus_t                 i_inst,
  input  logic                       i_es_allowin,
  input  bypass_bus_t                i_es_bypass,
  input  csr_pending_t               i_es_csr_pending,
  input  bypass_bus_t                i_ws_bypass,
  input  logic [`RV_WORD_WD-1:0]     i_rs1_data,
  input  logic [`RV_WORD_WD-1:0]     i_rs2_data,
  input  logic [`RV_WORD_WD-1:0]     i_csr_data,
  output logic                       o_inst_allowin,
  output logic                       o_ds_to_es_valid,
  output ds_to_es_bus_t              o_ds_to_es_bus,
  output logic [`RV_GPR_ADDR_WD-1:0] o_rs1,
  output logic [`RV_GPR_ADDR_WD-1:0] o_rs2,
  output csr_idx_t                   o_csr_idx
);

  logic                       ds_valid;
  fetch_bus_t                 ds_inst;
  logic                       ds_ready_go;
  logic                       ds_stall;
  logic [6:0]                 opcode;
  logic [2:0]                 funct3;
  logic [6:0]                 funct7;
  logic [`RV_GPR_ADDR_WD-1:0] rd;
  logic [`RV_CSR_ADDR_WD-1:0] csr_addr;
  logic [`RV_WORD_WD-1:0]     imm_i;
  logic [`RV_WORD_WD-1:0]     imm_u;
  logic [`RV_WORD_WD-1:0]     rs1_val;
  logic [`RV_WORD_WD-1:0]     rs2_val;
  logic [`RV_WORD_WD-1:0]     csr_old;
  alu_op_e                    op;
  logic                       legal;
  logic                       csr_hit;
  logic                       csr_rd;
  csr_idx_t                   csr_idx;

  stage_reg #(.payload_t(fetch_bus_t)) u_ds_reg (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_up_valid (i_inst_valid),
    .i_allowin  (o_inst_allowin),
    .i_up_data  (i_inst),
    .o_valid    (ds_valid),
    .o_data     (ds_inst)
  );

  assign opcode   = ds_inst.inst[6:0];
  assign rd       = ds_inst.inst[11:7];
  assign funct3   = ds_inst.inst[14:12];
  assign o_rs1    = ds_inst.inst[19:15];
  assign o_rs2    = ds_inst.inst[24:20];
  assign funct7   = ds_inst.inst[31:25];
  assign csr_addr = ds_inst.inst[31:20];
  assign imm_i    = {{20{ds_inst.inst[31]}}, ds_inst.inst[31:20]};
  assign imm_u    = {ds_inst.inst[31:12], 12'b0};

  always_comb begin
    csr_hit = 1'b1;
    csr_idx = '0;
    case (csr_addr)
      `RV_CSR_MSCRATCH: csr_idx = 2'd0;
      `RV_CSR_MTVEC:    csr_idx = 2'd1;
      `RV_CSR_MEPC:     csr_idx = 2'd2;
      `RV_CSR_MCAUSE:   csr_idx = 2'd3;
      default:          csr_hit = 1'b0;
    endcase
  end
  assign o_csr_idx = csr_idx;

  always_comb begin
    op    = ALU_ADD;
    legal = 1'b0;
    case (opcode)
      7'b0110011: begin
        legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000 && funct3 == 3'b000);
        case (funct3)
          3'b000:  op = funct7[5] ? ALU_SUB : ALU_ADD;
          3'b001:  op = ALU_SLL;
          3'b010:  op = ALU_SLT;
          3'b011:  op = ALU_SLTU;
          3'b100:  op = ALU_XOR;
          3'b101:  op = ALU_SRL;
          3'b110:  op = ALU_OR;
          default: op = ALU_AND;
        endcase
      end
      7'b0010011: begin
        legal = 1'b1;
        case (funct3)
          3'b000:  op = ALU_ADD;
          3'b010:  op = ALU_SLT;
          3'b100:  op = ALU_XOR;
          3'b110:  op = ALU_OR;
          3'b111:  op = ALU_AND;
          default: legal = 1'b0;
        endcase
      end
      7'b0110111: begin
        legal = 1'b1;
        op    = ALU_PASS_B;
      end
      7'b1110011: begin
        legal = csr_hit;
        case (funct3)
          3'b001:  op = ALU_CSRW;
          3'b010:  op = ALU_CSRS;
          3'b011:  op = ALU_CSRC;
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

  // execute wins over write-back, which wins over the register file
  function automatic logic [`RV_WORD_WD-1:0] fwd_gpr(
    input logic [`RV_GPR_ADDR_WD-1:0] addr,
    input logic [`RV_WORD_WD-1:0]     rf_data,
    input bypass_bus_t                es,
    input bypass_bus_t                ws
  );
    logic [`RV_WORD_WD-1:0] val;
    val = rf_data;
    if (addr != '0 && ws.gpr_wen && ws.gpr_waddr == addr) begin
      val = ws.gpr_wdata;
    end
    if (addr != '0 && es.gpr_wen && es.gpr_waddr == addr) begin
      val = es.gpr_wdata;
    end
    return val;
  endfunction

  assign rs1_val = fwd_gpr(o_rs1, i_rs1_data, i_es_bypass, i_ws_bypass);
  assign rs2_val = fwd_gpr(o_rs2, i_rs2_data, i_es_bypass, i_ws_bypass);
  // csr results only come back through write-back
  assign csr_old = (i_ws_bypass.csr_wen && i_ws_bypass.csr_idx == csr_idx) ?
                   i_ws_bypass.csr_wdata : i_csr_data;

  assign csr_rd   = legal && (opcode == 7'b1110011);
  assign ds_stall = ds_valid && csr_rd && i_es_csr_pending.pending &&
                    (i_es_csr_pending.idx == csr_idx);

  assign ds_ready_go      = !ds_stall;
  assign o_inst_allowin   = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_comb begin
    o_ds_to_es_bus.op      = op;
    o_ds_to_es_bus.src_a   = rs1_val;
    o_ds_to_es_bus.src_b   = (opcode == 7'b0110011) ? rs2_val :
                             (opcode == 7'b0110111) ? imm_u : imm_i;
    o_ds_to_es_bus.gpr_wen = legal && (rd != '0);
    o_ds_to_es_bus.rd      = rd;
    // set and clear with rs1 = x0 only read the CSR
    o_ds_to_es_bus.csr_wen = csr_rd && (op == ALU_CSRW || o_rs1 != '0);
    o_ds_to_es_bus.csr_idx = csr_idx;
    o_ds_to_es_bus.csr_old = csr_old;
    o_ds_to_es_bus.pc      = ds_inst.pc;
    o_ds_to_es_bus.inst    = ds_inst.inst;
  end

  // the CSR writer leaves execute on the next edge
  a_stall_one_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
    ds_stall |=> !ds_stall);

endmodule

// ==== execute_stage.sv ====
// single-cycle ALU; CSR results are not forwarded from here, decode stalls instead
`timescale 1ns/1ps
`include "rv_pipe_defines.svh"

module execute_stage
  import rv_pipe_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_reset,
  input  logic          i_ds_to_es_valid,
  input  ds_to_es_bus_t i_ds_to_es_bus,
  input  logic          i_ws_allowin,
  output logic          o_es_allowin,
  output logic          o_es_to_ws_valid,
  output es_to_ws_bus_t o_es_to_ws_bus,
  output bypass_bus_t   o_es_bypass,
  output csr_pending_t  o_es_csr_pending
);

  logic                   es_valid;
  logic                   es_ready_go;
  logic                   es_gpr_wen;
  ds_to_es_bus_t          es_bus;
  logic [4:0]             shamt;
  logic [`RV_WORD_WD-1:0] gpr_result;
  logic [`RV_WORD_WD-1:0] csr_result;

  stage_reg #(.payload_t(ds_to_es_bus_t)) u_es_reg (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_up_valid (i_ds_to_es_valid),
    .i_allowin  (o_es_allowin),
    .i_up_data  (i_ds_to_es_bus),
    .o_valid    (es_valid),
    .o_data     (es_bus)
  );

  assign es_ready_go      = 1'b1;
  assign o_es_allowin     = !es_valid || (es_ready_go && i_ws_allowin);
  assign o_es_to_ws_valid = es_valid && es_ready_go;

  assign shamt = es_bus.src_b[4:0];

  always_comb begin
    gpr_result = '0;
    csr_result = es_bus.csr_old;
    case (es_bus.op)
      ALU_ADD:    gpr_result = es_bus.src_a + es_bus.src_b;
      ALU_SUB:    gpr_result = es_bus.src_a - es_bus.src_b;
      ALU_AND:    gpr_result = es_bus.src_a & es_bus.src_b;
      ALU_OR:     gpr_result = es_bus.src_a | es_bus.src_b;
      ALU_XOR:    gpr_result = es_bus.src_a ^ es_bus.src_b;
      ALU_SLT:    gpr_result[0] = $signed(es_bus.src_a) < $signed(es_bus.src_b);
      ALU_SLTU:   gpr_result[0] = es_bus.src_a < es_bus.src_b;
      ALU_SLL:    gpr_result = es_bus.src_a << shamt;
      ALU_SRL:    gpr_result = es_bus.src_a >> shamt;
      ALU_PASS_B: gpr_result = es_bus.src_b;
      // rd always gets the old CSR value
      ALU_CSRW: begin
        gpr_result = es_bus.csr_old;
        csr_result = es_bus.src_a;
      end
      ALU_CSRS: begin
        gpr_result = es_bus.csr_old;
        csr_result = es_bus.csr_old | es_bus.src_a;
      end
      ALU_CSRC: begin
        gpr_result = es_bus.csr_old;
        csr_result = es_bus.csr_old & ~es_bus.src_a;
      end
      default:    gpr_result = '0;
    endcase
  end

  always_comb begin
    o_es_to_ws_bus.gpr_wen    = es_bus.gpr_wen;
    o_es_to_ws_bus.rd         = es_bus.rd;
    o_es_to_ws_bus.gpr_result = gpr_result;
    o_es_to_ws_bus.csr_wen    = es_bus.csr_wen;
    o_es_to_ws_bus.csr_idx    = es_bus.csr_idx;
    o_es_to_ws_bus.csr_result = csr_result;
    o_es_to_ws_bus.pc         = es_bus.pc;
    o_es_to_ws_bus.inst       = es_bus.inst;
  end

  // gpr fields only
  assign es_gpr_wen              = es_valid && es_bus.gpr_wen;
  assign o_es_bypass.gpr_wen     = es_gpr_wen;
  assign o_es_bypass.gpr_waddr   = es_gpr_wen ? es_bus.rd : '0;
  assign o_es_bypass.gpr_wdata   = es_gpr_wen ? gpr_result : '0;
  assign o_es_bypass.csr_wen     = 1'b0;
  assign o_es_bypass.csr_idx     = '0;
  assign o_es_bypass.csr_wdata   = '0;

  assign o_es_csr_pending.pending = es_valid && es_bus.csr_wen;
  assign o_es_csr_pending.idx     = es_bus.csr_idx;

endmodule

// ==== wb_stage.sv ====
// always ready; write enables leave this stage gated by its valid bit
`timescale 1ns/1ps

module wb_stage
  import rv_pipe_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_reset,
  input  logic          i_es_to_ws_valid,
  input  es_to_ws_bus_t i_es_to_ws_bus,
  output logic          o_ws_allowin,
  output ws_to_rf_bus_t o_ws_to_rf_bus,
  output bypass_bus_t   o_ws_bypass,
  output commit_t       o_commit
);

  logic          ws_valid;
  logic          ws_ready_go;
  logic          ws_gpr_wen;
  logic          ws_csr_wen;
  es_to_ws_bus_t ws_bus;

  stage_reg #(.payload_t(es_to_ws_bus_t)) u_ws_reg (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_up_valid (i_es_to_ws_valid),
    .i_allowin  (o_ws_allowin),
    .i_up_data  (i_es_to_ws_bus),
    .o_valid    (ws_valid),
    .o_data     (ws_bus)
  );

  assign ws_ready_go  = 1'b1;
  assign o_ws_allowin = !ws_valid || ws_ready_go;

  assign ws_gpr_wen = ws_valid && ws_bus.gpr_wen;
  assign ws_csr_wen = ws_valid && ws_bus.csr_wen;

  assign o_ws_to_rf_bus.gpr_wen   = ws_gpr_wen;
  assign o_ws_to_rf_bus.gpr_waddr = ws_bus.rd;
  assign o_ws_to_rf_bus.gpr_wdata = ws_bus.gpr_result;
  assign o_ws_to_rf_bus.csr_wen   = ws_csr_wen;
  assign o_ws_to_rf_bus.csr_idx   = ws_bus.csr_idx;
  assign o_ws_to_rf_bus.csr_wdata = ws_bus.csr_result;

  // bypass fields read as zero unless the matching write is live
  assign o_ws_bypass.gpr_wen   = ws_gpr_wen;
  assign o_ws_bypass.gpr_waddr = ws_gpr_wen ? ws_bus.rd : '0;
  assign o_ws_bypass.gpr_wdata = ws_gpr_wen ? ws_bus.gpr_result : '0;
  assign o_ws_bypass.csr_wen   = ws_csr_wen;
  assign o_ws_bypass.csr_idx   = ws_csr_wen ? ws_bus.csr_idx : '0;
  assign o_ws_bypass.csr_wdata = ws_csr_wen ? ws_bus.csr_result : '0;

  assign o_commit.valid     = ws_valid && ws_ready_go;
  assign o_commit.pc        = ws_bus.pc;
  assign o_commit.inst      = ws_bus.inst;
  assign o_commit.gpr_wen   = ws_gpr_wen;
  assign o_commit.rd        = ws_bus.rd;
  assign o_commit.gpr_wdata = ws_bus.gpr_result;
  assign o_commit.csr_wen   = ws_csr_wen;
  assign o_commit.csr_idx   = ws_bus.csr_idx;
  assign o_commit.csr_wdata = ws_bus.csr_result;

  // decode must have dropped rd = x0 writes two stages earlier
  a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_reset)
    ws_gpr_wen |-> ws_bus.rd != '0);

endmodule

// ==== rv_pipe_top.sv ====
// pc and instruction come from outside; the source must hold i_inst while o_inst_allowin is low
`timescale 1ns/1ps
`include "rv_pipe_defines.svh"

module rv_pipe_top
  import rv_pipe_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset,
  input  logic       i_inst_valid,
  input  fetch_bus_t i_inst,
  output logic       o_inst_allowin,
  output commit_t    o_commit
);

  logic                       es_allowin;
  logic                       ws_allowin;
  logic                       ds_to_es_valid;
  logic                       es_to_ws_valid;
  ds_to_es_bus_t              ds_to_es_bus;
  es_to_ws_bus_t              es_to_ws_bus;
  ws_to_rf_bus_t              ws_to_rf_bus;
  bypass_bus_t                es_bypass;
  bypass_bus_t                ws_bypass;
  csr_pending_t               es_csr_pending;
  logic [`RV_GPR_ADDR_WD-1:0] rs1;
  logic [`RV_GPR_ADDR_WD-1:0] rs2;
  csr_idx_t                   csr_idx;
  logic [`RV_WORD_WD-1:0]     rs1_data;
  logic [`RV_WORD_WD-1:0]     rs2_data;
  logic [`RV_WORD_WD-1:0]     csr_data;

  decode_stage u_decode_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_inst_valid     (i_inst_valid),
    .i_inst           (i_inst),
    .i_es_allowin     (es_allowin),
    .i_es_bypass      (es_bypass),
    .i_es_csr_pending (es_csr_pending),
    .i_ws_bypass      (ws_bypass),
    .i_rs1_data       (rs1_data),
    .i_rs2_data       (rs2_data),
    .i_csr_data       (csr_data),
    .o_inst_allowin   (o_inst_allowin),
    .o_ds_to_es_valid (ds_to_es_valid),
    .o_ds_to_es_bus   (ds_to_es_bus),
    .o_rs1            (rs1),
    .o_rs2            (rs2),
    .o_csr_idx        (csr_idx)
  );

  execute_stage u_execute_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_ds_to_es_valid (ds_to_es_valid),
    .i_ds_to_es_bus   (ds_to_es_bus),
    .i_ws_allowin     (ws_allowin),
    .o_es_allowin     (es_allowin),
    .o_es_to_ws_valid (es_to_ws_valid),
    .o_es_to_ws_bus   (es_to_ws_bus),
    .o_es_bypass      (es_bypass),
    .o_es_csr_pending (es_csr_pending)
  );

  wb_stage u_wb_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_es_to_ws_valid (es_to_ws_valid),
    .i_es_to_ws_bus   (es_to_ws_bus),
    .o_ws_allowin     (ws_allowin),
    .o_ws_to_rf_bus   (ws_to_rf_bus),
    .o_ws_bypass      (ws_bypass),
    .o_commit         (o_commit)
  );

  reg_file u_reg_file (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_csr_idx  (csr_idx),
    .i_wb       (ws_to_rf_bus),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .o_csr_data (csr_data)
  );

endmodule

// ==== tb_rv_pipe.sv ====
// self-checking testbench; fixed-seed random instruction stream checked in order against a model
`timescale 1ns/1ps
`include "rv_pipe_defines.svh"

module tb_rv_pipe
  import rv_pipe_pkg::*;
;

  localparam int NUM_INST     = 400;
  localparam int CLK_NS       = 8;
  localparam int RESET_CYCLES = 3;
  localparam int WATCHDOG_NS  = (NUM_INST * 4 + RESET_CYCLES) * CLK_NS;

  logic       clk;
  logic       reset;
  logic       inst_valid;
  fetch_bus_t inst_in;
  logic       inst_allowin;
  commit_t    commit;

  logic [`RV_WORD_WD-1:0] m_gpr [`RV_GPR_NUM];
  logic [`RV_WORD_WD-1:0] m_csr [`RV_CSR_NUM];
  logic [31:0]            lfsr;
  logic [31:0]            last_csr;
  logic [31:0]            pc;
  logic [31:0]            word;
  logic [31:0]            pick;
  commit_t                exp_q[$];
  commit_t                predicted;
  commit_t                exp_head;
  logic                   exp_avail  = 1'b0;
  logic                   none_taken = 1'b1;
  logic                   took       = 1'b0;
  int                     n_sent     = 0;
  int                     n_taken    = 0;
  int                     n_commit   = 0;
  int                     n_stall    = 0;

  rv_pipe_top u_rv_pipe_top (
    .i_clk          (clk),
    .i_reset        (reset),
    .i_inst_valid   (inst_valid),
    .i_inst         (inst_in),
    .o_inst_allowin (inst_allowin),
    .o_commit       (commit)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // mostly x0..x7 so that neighbours depend on each other
  task automatic pick_reg(output logic [4:0] r);
    logic [31:0] v;
    take_bits(2, v);
    if (v[1:0] == 2'd0) begin
      take_bits(5, v);
    end else begin
      take_bits(3, v);
    end
    r = v[4:0];
  endtask

  function automatic logic [11:0] csr_addr_of(input logic [1:0] k);
    case (k)
      2'd0:    return `RV_CSR_MSCRATCH;
      2'd1:    return `RV_CSR_MTVEC;
      2'd2:    return `RV_CSR_MEPC;
      default: return `RV_CSR_MCAUSE;
    endcase
  endfunction

  function automatic int csr_slot(input logic [11:0] addr);
    case (addr)
      `RV_CSR_MSCRATCH: return 0;
      `RV_CSR_MTVEC:    return 1;
      `RV_CSR_MEPC:     return 2;
      `RV_CSR_MCAUSE:   return 3;
      default:          return -1;
    endcase
  endfunction

  task automatic make_inst(output logic [31:0] w);
    logic [31:0] cls;
    logic [31:0] f3;
    logic [31:0] sel;
    logic [31:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    take_bits(3, cls);
    pick_reg(rd);
    pick_reg(rs1);
    pick_reg(rs2);
    case (cls)
      2: begin
        take_bits(3, sel);
        take_bits(12, imm);
        case (sel)
          1:       f3 = 2;
          2, 6:    f3 = 4;
          3, 7:    f3 = 6;
          4:       f3 = 7;
          default: f3 = 0;
        endcase
        w = {imm[11:0], rs1, f3[2:0], rd, 7'b0010011};
      end
      3: begin
        take_bits(20, imm);
        w = {imm[19:0], rd, 7'b0110111};
      end
      4, 5: begin
        take_bits(2, f3);
        if (f3 == 0) begin
          f3 = 1;
        end
        // half the time stay on the previous CSR to provoke the hazard
        take_bits(1, sel);
        if (!sel[0]) begin
          take_bits(2, last_csr);
        end
        w = {csr_addr_of(last_csr[1:0]), rs1, f3[2:0], rd, 7'b1110011};
      end
      6: begin
        take_bits(2, sel);
        case (sel)
          0:       begin
            take_bits(25, imm);
            w = {imm[24:0], 7'b0000011};
          end
          1:       w = {12'h300, rs1, 3'b010, rd, 7'b1110011};
          2:       w = {7'h00, rs2, rs1, 3'b001, rd, 7'b0010011};
          default: w = {7'h20, rs2, rs1, 3'b101, rd, 7'b0110011};
        endcase
      end
      default: begin
        take_bits(3, f3);
        take_bits(1, sel);
        w = {(f3 == 0 && sel[0]) ? 7'h20 : 7'h00, rs2, rs1, f3[2:0], rd, 7'b0110011};
      end
    endcase
  endtask

  // architectural model, one instruction at a time, no pipeline
  task automatic model_step(input fetch_bus_t f, output commit_t c);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] old;
    logic [31:0] res;
    logic [31:0] nw;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        ok;
    logic        wr_csr;
    int          idx;
    w      = f.inst;
    rd     = w[11:7];
    f3     = w[14:12];
    rs1    = w[19:15];
    f7     = w[31:25];
    a      = m_gpr[rs1];
    b      = m_gpr[w[24:20]];
    imm    = {{20{w[31]}}, w[31:20]};
    idx    = csr_slot(w[31:20]);
    ok     = 1'b0;
    wr_csr = 1'b0;
    res    = '0;
    nw     = '0;
    case (w[6:0])
      7'b0110011: begin
        ok = (f7 == 7'h00) || (f7 == 7'h20 && f3 == 3'd0);
        case (f3)
          3'd0:    res = f7[5] ? a - b : a + b;
          3'd1:    res = a << b[4:0];
          3'd2:    res = {31'b0, $signed(a) < $signed(b)};
          3'd3:    res = {31'b0, a < b};
          3'd4:    res = a ^ b;
          3'd5:    res = a >> b[4:0];
          3'd6:    res = a | b;
          default: res = a & b;
        endcase
      end
      7'b0010011: begin
        ok = 1'b1;
        case (f3)
          3'd0:    res = a + imm;
          3'd2:    res = {31'b0, $signed(a) < $signed(imm)};
          3'd4:    res = a ^ imm;
          3'd6:    res = a | imm;
          3'd7:    res = a & imm;
          default: ok = 1'b0;
        endcase
      end
      7'b0110111: begin
        ok  = 1'b1;
        res = {w[31:12], 12'b0};
      end
      7'b1110011: begin
        ok = (idx >= 0) && (f3 >= 3'd1) && (f3 <= 3'd3);
        if (ok) begin
          old    = m_csr[idx];
          res    = old;
          nw     = (f3 == 3'd1) ? a : (f3 == 3'd2) ? (old | a) : (old & ~a);
          wr_csr = (f3 == 3'd1) || (rs1 != 5'd0);
        end
      end
      default: ok = 1'b0;
    endcase
    c           = '0;
    c.valid     = 1'b1;
    c.pc        = f.pc;
    c.inst      = w;
    c.gpr_wen   = ok && (rd != 5'd0);
    c.rd        = rd;
    c.gpr_wdata = res;
    c.csr_wen   = wr_csr;
    c.csr_idx   = csr_idx_t'(idx);
    c.csr_wdata = nw;
    if (c.gpr_wen) begin
      m_gpr[rd] = res;
    end
    if (wr_csr) begin
      m_csr[idx] = nw;
    end
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAIL %0t: %s, commit pc %h inst %h", $time, msg, commit.pc, commit.inst);
    $display("TEST FAILED");
    $fatal(1, "commit check failed");
  endtask

  // mid-cycle bookkeeping, everything here is stable at the falling edge
  always @(negedge clk) begin
    took = 1'b0;
    if (!reset) begin
      if (commit.valid) begin
        n_commit++;
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
        end
      end
      if (!inst_allowin) begin
        n_stall++;
      end
      if (inst_valid && inst_allowin) begin
        model_step(inst_in, predicted);
        exp_q.push_back(predicted);
        n_taken++;
        took = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    exp_avail  <= (exp_q.size() != 0);
    none_taken <= (n_taken == 0);
    if (exp_q.size() != 0) begin
      exp_head <= exp_q[0];
    end
  end

  a_idle_after_reset: assert property (@(negedge clk) disable iff (reset)
    none_taken |-> (inst_allowin && !commit.valid))
    else report_mismatch("pipeline not idle before the first instruction");
  a_commit_expected: assert property (@(negedge clk) disable iff (reset)
    commit.valid |-> exp_avail)
    else report_mismatch("commit with no outstanding instruction");
  a_commit_order: assert property (@(negedge clk) disable iff (reset)
    commit.valid |-> (commit.pc == exp_head.pc && commit.inst == exp_head.inst))
    else report_mismatch("pc or instruction out of order");
  a_gpr_wen: assert property (@(negedge clk) disable iff (reset)
    commit.valid |-> (commit.gpr_wen == exp_head.gpr_wen))
    else report_mismatch("gpr write enable differs");
  a_gpr_data: assert property (@(negedge clk) disable iff (reset)
    commit.valid && exp_head.gpr_wen |->
      (commit.rd == exp_head.rd && commit.gpr_wdata == exp_head.gpr_wdata))
    else report_mismatch("gpr write address or data differs");
  a_csr_wen: assert property (@(negedge clk) disable iff (reset)
    commit.valid |-> (commit.csr_wen == exp_head.csr_wen))
    else report_mismatch("csr write enable differs");
  a_csr_data: assert property (@(negedge clk) disable iff (reset)
    commit.valid && exp_head.csr_wen |->
      (commit.csr_idx == exp_head.csr_idx && commit.csr_wdata == exp_head.csr_wdata))
    else report_mismatch("csr index or data differs");
  // a CSR hazard costs exactly one cycle
  a_stall_short: assert property (@(negedge clk) disable iff (reset)
    !inst_allowin |=> inst_allowin)
    else report_mismatch("allowin low for more than one cycle");

  initial begin
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst_in    = '0;
    lfsr       = 32'h1fb3;
    last_csr   = '0;
    pc         = '0;
    for (int i = 0; i < `RV_GPR_NUM; i++) begin
      m_gpr[i] = '0;
    end
    for (int j = 0; j < `RV_CSR_NUM; j++) begin
      m_csr[j] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    while (n_sent < NUM_INST) begin
      take_bits(3, pick);
      if (pick[2:0] == 3'b111) begin
        inst_valid = 1'b0;
        @(posedge clk);
        #1;
      end else begin
        make_inst(word);
        inst_valid   = 1'b1;
        inst_in.pc   = pc;
        inst_in.inst = word;
        @(posedge clk);
        #1;
        // hold until the pipeline takes it
        while (!took) begin
          @(posedge clk);
          #1;
        end
        inst_valid = 1'b0;
        pc         = pc + 32'd4;
        n_sent++;
      end
    end
    wait (n_commit == n_taken);
    repeat (4) @(posedge clk);
    if (exp_q.size() != 0 || n_commit != NUM_INST || n_stall == 0) begin
      $display("end of run: %0d of %0d instructions committed, %0d left, %0d stall cycles",
               n_commit, NUM_INST, exp_q.size(), n_stall);
      $display("TEST FAILED");
      $fatal(1, "end of run check failed");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: only %0d of %0d instructions committed", n_commit, NUM_INST);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== rv_pipe.f ====
+incdir+.
rv_pipe_pkg.sv
stage_reg.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
wb_stage.sv
rv_pipe_top.sv
tb_rv_pipe.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line is printed
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_rv_pipe -f rv_pipe.f -o sim_rv_pipe

out=$(./obj_dir/sim_rv_pipe 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi
